//--- include/arp_consts.svh
`ifndef ARP_CONSTS_SVH
`define ARP_CONSTS_SVH

// frame layout, in bytes
`define ETH_HDR_LEN 14
`define ARP_HDR_LEN 28

// ethertype carried in the ethernet header
`define ETHERTYPE_ARP 16'h0806

// arp body fields for ethernet hardware and ipv4 protocol
`define ARP_HTYPE_ETH 16'h0001
`define ARP_PTYPE_IPV4 16'h0800

// address lengths, MAC is 6 bytes and IPv4 is 4
`define ARP_HLEN_ETH 8'd6
`define ARP_PLEN_IPV4 8'd4

`endif

//--- hdl/arp_pkg.sv
package arp_pkg;

    // arp operation field, big endian on the wire
    typedef enum logic [15:0] {
        ARP_OP_REQUEST = 16'd1,
        ARP_OP_REPLY   = 16'd2
    } arp_oper_e;

    // ethernet header capture
    typedef enum logic [1:0] {
        ST_HDR,
        ST_HOLD,
        ST_PAYLOAD,
        ST_DROP
    } eth_rx_state_e;

    // arp body decode
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BODY,
        ST_WAIT_LAST,
        ST_OUT
    } arp_dec_state_e;

endpackage

//--- hdl/eth_hdr_rx.sv
`timescale 1ns/1ps
`include "arp_consts.svh"

module eth_hdr_rx (
    input  logic        clk,
    input  logic        rst,
    input  logic [7:0]  s_tdata,
    input  logic        s_tvalid,
    output logic        s_tready,
    input  logic        s_tlast,
    input  logic        s_tuser,
    output logic        hdr_valid,
    input  logic        hdr_ready,
    output logic [47:0] eth_dest_mac,
    output logic [47:0] eth_src_mac,
    output logic [15:0] eth_type,
    output logic [7:0]  pay_tdata,
    output logic        pay_tvalid,
    input  logic        pay_tready,
    output logic        pay_tlast,
    output logic        pay_tuser,
    output logic        err_short_eth
);
    import arp_pkg::*;

    localparam int HDR_BITS = `ETH_HDR_LEN * 8;

    eth_rx_state_e       state;
    eth_rx_state_e       state_next;
    logic [3:0]          cnt;
    logic [HDR_BITS-1:0] hdr_sr;
    logic                cap_rdy;
    logic                in_beat;
    logic                hdr_beat;
    logic                hdr_last;

    assign in_beat  = s_tvalid && s_tready;
    assign hdr_beat = in_beat && (state == ST_HDR);
    assign hdr_last = (cnt == 4'(`ETH_HDR_LEN - 1));

    always_comb begin
        state_next = state;
        case (state)
            ST_HDR: begin
                // tlast on or before byte 14 leaves no payload to decode
                if (hdr_beat && (s_tlast || s_tuser)) begin
                    state_next = s_tlast ? ST_HDR : ST_DROP;
                end else if (hdr_beat && hdr_last) begin
                    state_next = ST_HOLD;
                end
            end
            ST_HOLD: begin
                if (hdr_ready) begin
                    state_next = ST_PAYLOAD;
                end
            end
            ST_PAYLOAD, ST_DROP: begin
                if (in_beat && s_tlast) begin
                    state_next = ST_HDR;
                end
            end
            default: state_next = ST_HDR;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= ST_HDR;
            cnt           <= 4'd0;
            cap_rdy       <= 1'b0;
            err_short_eth <= 1'b0;
        end else begin
            state         <= state_next;
            cap_rdy       <= (state_next == ST_HDR) || (state_next == ST_DROP);
            err_short_eth <= hdr_beat && s_tlast;
            if (hdr_beat) begin
                cnt <= (s_tlast || s_tuser || hdr_last) ? 4'd0 : cnt + 4'd1;
            end
        end
    end

    // header bytes arrive big endian, shift in from the bottom
    always_ff @(posedge clk) begin
        if (hdr_beat) begin
            hdr_sr <= {hdr_sr[HDR_BITS-9:0], s_tdata};
        end
    end

    assign eth_dest_mac = hdr_sr[111:64];
    assign eth_src_mac  = hdr_sr[63:16];
    assign eth_type     = hdr_sr[15:0];
    assign hdr_valid    = (state == ST_HOLD);

    // payload is a straight pass-through once the header is taken
    assign pay_tdata  = s_tdata;
    assign pay_tlast  = s_tlast;
    assign pay_tuser  = s_tuser;
    assign pay_tvalid = s_tvalid && (state == ST_PAYLOAD);
    assign s_tready   = (state == ST_PAYLOAD) ? pay_tready : cap_rdy;

    // input stream stalls while a header waits for stage 2
    a_hold_stall: assert property (
        @(posedge clk) disable iff (rst) !(hdr_valid && s_tready)
    );

endmodule

//--- hdl/arp_rx_decode.sv
`timescale 1ns/1ps
`include "arp_consts.svh"

module arp_rx_decode (
    input  logic        clk,
    input  logic        rst,
    input  logic        hdr_valid,
    output logic        hdr_ready,
    input  logic [47:0] eth_dest_mac,
    input  logic [47:0] eth_src_mac,
    input  logic [15:0] eth_type,
    input  logic [7:0]  pay_tdata,
    input  logic        pay_tvalid,
    output logic        pay_tready,
    input  logic        pay_tlast,
    input  logic        pay_tuser,
    output logic        frame_valid,
    input  logic        frame_ready,
    output logic [47:0] out_eth_dest_mac,
    output logic [47:0] out_eth_src_mac,
    output logic [15:0] out_eth_type,
    output logic [15:0] arp_htype,
    output logic [15:0] arp_ptype,
    output logic [7:0]  arp_hlen,
    output logic [7:0]  arp_plen,
    output logic [15:0] arp_oper,
    output logic [47:0] arp_sha,
    output logic [31:0] arp_spa,
    output logic [47:0] arp_tha,
    output logic [31:0] arp_tpa,
    output logic        busy,
    output logic        err_early_term,
    output logic        err_invalid_hdr
);
    import arp_pkg::*;

    localparam logic [4:0] LAST_PTR = 5'(`ARP_HDR_LEN - 1);

    arp_dec_state_e state;
    arp_dec_state_e state_next;
    logic [4:0]     ptr;
    logic [4:0]     ptr_next;
    logic           hdr_beat;
    logic           pay_beat;
    logic           err_early_next;
    logic           err_hdr_next;

    assign hdr_beat    = hdr_valid && hdr_ready;
    assign pay_beat    = pay_tvalid && pay_tready;
    assign frame_valid = (state == ST_OUT);

    always_comb begin
        state_next     = state;
        ptr_next       = ptr;
        err_early_next = 1'b0;
        err_hdr_next   = 1'b0;
        case (state)
            ST_IDLE: begin
                if (hdr_beat) begin
                    state_next = ST_BODY;
                    ptr_next   = 5'd0;
                end
            end
            ST_BODY, ST_WAIT_LAST: begin
                if (pay_beat) begin
                    if (state == ST_BODY) begin
                        ptr_next = ptr + 5'd1;
                        if (ptr == LAST_PTR) begin
                            state_next = ST_WAIT_LAST;
                        end
                    end
                    if (pay_tlast) begin
                        state_next = ST_IDLE;
                        ptr_next   = 5'd0;
                        if (state == ST_BODY && ptr != LAST_PTR) begin
                            err_early_next = 1'b1;
                        end else if (arp_hlen != `ARP_HLEN_ETH ||
                                     arp_plen != `ARP_PLEN_IPV4) begin
                            // hlen and plen were captured several bytes back
                            err_hdr_next = 1'b1;
                        end else if (!pay_tuser) begin
                            state_next = ST_OUT;
                        end
                    end
                end
            end
            ST_OUT: begin
                if (frame_ready) begin
                    state_next = ST_IDLE;
                end
            end
            default: state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state           <= ST_IDLE;
            ptr             <= 5'd0;
            hdr_ready       <= 1'b0;
            pay_tready      <= 1'b0;
            busy            <= 1'b0;
            err_early_term  <= 1'b0;
            err_invalid_hdr <= 1'b0;
        end else begin
            state           <= state_next;
            ptr             <= ptr_next;
            hdr_ready       <= (state_next == ST_IDLE);
            pay_tready      <= (state_next == ST_BODY) || (state_next == ST_WAIT_LAST);
            busy            <= (state_next == ST_BODY);
            err_early_term  <= err_early_next;
            err_invalid_hdr <= err_hdr_next;
        end
    end

    always_ff @(posedge clk) begin
        if (hdr_beat) begin
            out_eth_dest_mac <= eth_dest_mac;
            out_eth_src_mac  <= eth_src_mac;
            out_eth_type     <= eth_type;
        end
        // one body byte per beat, msb first
        if (pay_beat && state == ST_BODY) begin
            case (ptr)
                5'd0:  arp_htype[15:8] <= pay_tdata;
                5'd1:  arp_htype[7:0]  <= pay_tdata;
                5'd2:  arp_ptype[15:8] <= pay_tdata;
                5'd3:  arp_ptype[7:0]  <= pay_tdata;
                5'd4:  arp_hlen        <= pay_tdata;
                5'd5:  arp_plen        <= pay_tdata;
                5'd6:  arp_oper[15:8]  <= pay_tdata;
                5'd7:  arp_oper[7:0]   <= pay_tdata;
                5'd8:  arp_sha[47:40]  <= pay_tdata;
                5'd9:  arp_sha[39:32]  <= pay_tdata;
                5'd10: arp_sha[31:24]  <= pay_tdata;
                5'd11: arp_sha[23:16]  <= pay_tdata;
                5'd12: arp_sha[15:8]   <= pay_tdata;
                5'd13: arp_sha[7:0]    <= pay_tdata;
                5'd14: arp_spa[31:24]  <= pay_tdata;
                5'd15: arp_spa[23:16]  <= pay_tdata;
                5'd16: arp_spa[15:8]   <= pay_tdata;
                5'd17: arp_spa[7:0]    <= pay_tdata;
                5'd18: arp_tha[47:40]  <= pay_tdata;
                5'd19: arp_tha[39:32]  <= pay_tdata;
                5'd20: arp_tha[31:24]  <= pay_tdata;
                5'd21: arp_tha[23:16]  <= pay_tdata;
                5'd22: arp_tha[15:8]   <= pay_tdata;
                5'd23: arp_tha[7:0]    <= pay_tdata;
                5'd24: arp_tpa[31:24]  <= pay_tdata;
                5'd25: arp_tpa[23:16]  <= pay_tdata;
                5'd26: arp_tpa[15:8]   <= pay_tdata;
                5'd27: arp_tpa[7:0]    <= pay_tdata;
                default: ;
            endcase
        end
    end

    // a pending frame takes neither a new header nor payload
    a_out_stall: assert property (
        @(posedge clk) disable iff (rst) frame_valid |-> !hdr_ready && !pay_tready
    );

endmodule

//--- hdl/arp_rx_filter.sv
`timescale 1ns/1ps
`include "arp_consts.svh"

module arp_rx_filter (
    input  logic               clk,
    input  logic               rst,
    input  logic [31:0]        local_ip,
    input  logic               frame_valid,
    output logic               frame_ready,
    input  logic [15:0]        eth_type,
    input  logic [15:0]        arp_htype,
    input  logic [15:0]        arp_ptype,
    input  arp_pkg::arp_oper_e arp_oper,
    input  logic [47:0]        arp_sha,
    input  logic [31:0]        arp_spa,
    input  logic [31:0]        arp_tpa,
    output logic               req_valid,
    input  logic               req_ready,
    output logic [47:0]        req_sha,
    output logic [31:0]        req_spa,
    output logic               upd_valid,
    output logic [31:0]        upd_ip,
    output logic [47:0]        upd_mac,
    output logic [15:0]        drop_count
);
    import arp_pkg::*;

    logic accept;
    logic ours;
    logic is_req;
    logic is_rep;

    // a pending request blocks new frames
    assign frame_ready = !req_valid;
    assign accept      = frame_valid && frame_ready;

    assign ours = (eth_type == `ETHERTYPE_ARP) &&
                  (arp_htype == `ARP_HTYPE_ETH) &&
                  (arp_ptype == `ARP_PTYPE_IPV4) &&
                  (arp_tpa == local_ip);

    assign is_req = ours && (arp_oper == ARP_OP_REQUEST);
    assign is_rep = ours && (arp_oper == ARP_OP_REPLY);

    always_ff @(posedge clk) begin
        if (rst) begin
            req_valid  <= 1'b0;
            upd_valid  <= 1'b0;
            drop_count <= 16'd0;
        end else begin
            upd_valid <= accept && is_rep;
            if (req_valid && req_ready) begin
                req_valid <= 1'b0;
            end else if (accept && is_req) begin
                req_valid <= 1'b1;
            end
            // counter sticks at all ones
            if (accept && !is_req && !is_rep && drop_count != 16'hffff) begin
                drop_count <= drop_count + 16'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept && is_req) begin
            req_sha <= arp_sha;
            req_spa <= arp_spa;
        end
        if (accept && is_rep) begin
            upd_ip  <= arp_spa;
            upd_mac <= arp_sha;
        end
    end

    a_req_hold: assert property (
        @(posedge clk) disable iff (rst)
        req_valid && !req_ready |=> req_valid && $stable(req_sha) && $stable(req_spa)
    );

endmodule

//--- hdl/arp_rx_top.sv
`timescale 1ns/1ps

module arp_rx_top (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] local_ip,
    input  logic [7:0]  s_tdata,
    input  logic        s_tvalid,
    output logic        s_tready,
    input  logic        s_tlast,
    input  logic        s_tuser,
    output logic        req_valid,
    input  logic        req_ready,
    output logic [47:0] req_sha,
    output logic [31:0] req_spa,
    output logic        upd_valid,
    output logic [31:0] upd_ip,
    output logic [47:0] upd_mac,
    output logic [15:0] drop_count,
    output logic        busy,
    output logic        err_short_eth,
    output logic        err_early_term,
    output logic        err_invalid_hdr
);
    import arp_pkg::*;

    // stage 1 to stage 2
    logic        hdr_valid;
    logic        hdr_ready;
    logic [47:0] eth_dest_mac;
    logic [47:0] eth_src_mac;
    logic [15:0] eth_type;
    logic [7:0]  pay_tdata;
    logic        pay_tvalid;
    logic        pay_tready;
    logic        pay_tlast;
    logic        pay_tuser;

    // stage 2 to stage 3
    logic        frame_valid;
    logic        frame_ready;
    logic [15:0] frm_eth_type;
    logic [15:0] arp_htype;
    logic [15:0] arp_ptype;
    logic [15:0] arp_oper;
    logic [47:0] arp_sha;
    logic [31:0] arp_spa;
    logic [31:0] arp_tpa;

    eth_hdr_rx u_eth_hdr_rx (
        .clk           (clk),
        .rst           (rst),
        .s_tdata       (s_tdata),
        .s_tvalid      (s_tvalid),
        .s_tready      (s_tready),
        .s_tlast       (s_tlast),
        .s_tuser       (s_tuser),
        .hdr_valid     (hdr_valid),
        .hdr_ready     (hdr_ready),
        .eth_dest_mac  (eth_dest_mac),
        .eth_src_mac   (eth_src_mac),
        .eth_type      (eth_type),
        .pay_tdata     (pay_tdata),
        .pay_tvalid    (pay_tvalid),
        .pay_tready    (pay_tready),
        .pay_tlast     (pay_tlast),
        .pay_tuser     (pay_tuser),
        .err_short_eth (err_short_eth)
    );

    // the filter ignores the MAC addresses, address lengths and target MAC
    arp_rx_decode u_arp_rx_decode (
        .clk              (clk),
        .rst              (rst),
        .hdr_valid        (hdr_valid),
        .hdr_ready        (hdr_ready),
        .eth_dest_mac     (eth_dest_mac),
        .eth_src_mac      (eth_src_mac),
        .eth_type         (eth_type),
        .pay_tdata        (pay_tdata),
        .pay_tvalid       (pay_tvalid),
        .pay_tready       (pay_tready),
        .pay_tlast        (pay_tlast),
        .pay_tuser        (pay_tuser),
        .frame_valid      (frame_valid),
        .frame_ready      (frame_ready),
        .out_eth_dest_mac (),
        .out_eth_src_mac  (),
        .out_eth_type     (frm_eth_type),
        .arp_htype        (arp_htype),
        .arp_ptype        (arp_ptype),
        .arp_hlen         (),
        .arp_plen         (),
        .arp_oper         (arp_oper),
        .arp_sha          (arp_sha),
        .arp_spa          (arp_spa),
        .arp_tha          (),
        .arp_tpa          (arp_tpa),
        .busy             (busy),
        .err_early_term   (err_early_term),
        .err_invalid_hdr  (err_invalid_hdr)
    );

    arp_rx_filter u_arp_rx_filter (
        .clk         (clk),
        .rst         (rst),
        .local_ip    (local_ip),
        .frame_valid (frame_valid),
        .frame_ready (frame_ready),
        .eth_type    (frm_eth_type),
        .arp_htype   (arp_htype),
        .arp_ptype   (arp_ptype),
        .arp_oper    (arp_oper_e'(arp_oper)),
        .arp_sha     (arp_sha),
        .arp_spa     (arp_spa),
        .arp_tpa     (arp_tpa),
        .req_valid   (req_valid),
        .req_ready   (req_ready),
        .req_sha     (req_sha),
        .req_spa     (req_spa),
        .upd_valid   (upd_valid),
        .upd_ip      (upd_ip),
        .upd_mac     (upd_mac),
        .drop_count  (drop_count)
    );

endmodule

//--- verif/arp_rx_tb.sv
`timescale 1ns/1ps
`include "arp_consts.svh"

module arp_rx_tb;
    import arp_pkg::*;

    // about 12 frames of 60 cycles each, with margin
    localparam int CYCLE_LIMIT = 3000;
    localparam logic [31:0] LOCAL_IP = 32'hc0a8_0164;
    localparam int ARP_FRAME_LEN = `ETH_HDR_LEN + `ARP_HDR_LEN;

    typedef logic [7:0] byte_q_t [$];

    logic        clk;
    logic        rst;
    logic [31:0] local_ip;
    logic [7:0]  s_tdata;
    logic        s_tvalid;
    logic        s_tready;
    logic        s_tlast;
    logic        s_tuser;
    logic        req_valid;
    logic        req_ready;
    logic [47:0] req_sha;
    logic [31:0] req_spa;
    logic        upd_valid;
    logic [31:0] upd_ip;
    logic [47:0] upd_mac;
    logic [15:0] drop_count;
    logic        busy;
    logic        err_short_eth;
    logic        err_early_term;
    logic        err_invalid_hdr;

    logic [47:0] req_sha_q [$];
    logic [31:0] req_spa_q [$];
    logic [31:0] upd_ip_q [$];
    logic [47:0] upd_mac_q [$];
    int          n_short;
    int          n_early;
    int          n_inv;
    int          n_busy;
    int          errors;
    int          checks;
    int          cycles;
    int          sent_bytes;
    integer      seed;

    arp_rx_top DUT (
        .clk             (clk),
        .rst             (rst),
        .local_ip        (local_ip),
        .s_tdata         (s_tdata),
        .s_tvalid        (s_tvalid),
        .s_tready        (s_tready),
        .s_tlast         (s_tlast),
        .s_tuser         (s_tuser),
        .req_valid       (req_valid),
        .req_ready       (req_ready),
        .req_sha         (req_sha),
        .req_spa         (req_spa),
        .upd_valid       (upd_valid),
        .upd_ip          (upd_ip),
        .upd_mac         (upd_mac),
        .drop_count      (drop_count),
        .busy            (busy),
        .err_short_eth   (err_short_eth),
        .err_early_term  (err_early_term),
        .err_invalid_hdr (err_invalid_hdr)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: no result after %0d cycles, the DUT stopped responding", cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    // event monitors, outputs are registered so pre-edge values are sampled
    always @(posedge clk) begin
        if (!rst) begin
            if (req_valid && req_ready) begin
                req_sha_q.push_back(req_sha);
                req_spa_q.push_back(req_spa);
            end
            if (upd_valid) begin
                upd_ip_q.push_back(upd_ip);
                upd_mac_q.push_back(upd_mac);
            end
            if (err_short_eth) n_short++;
            if (err_early_term) n_early++;
            if (err_invalid_hdr) n_inv++;
            if (busy) n_busy++;
        end
    end

    task automatic check_val(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] t=%0t %s expected 0x%0h actual 0x%0h", $time, name,
                     expected, actual);
        end
    endtask

    // ethernet header, then arp body, then pad or cut to len bytes
    function automatic byte_q_t build_arp(input logic [15:0] etype, input logic [15:0] ptype,
                                          input logic [7:0] hlen, input logic [15:0] oper,
                                          input logic [47:0] sha, input logic [31:0] spa,
                                          input logic [31:0] tpa, input int len);
        byte_q_t                   q;
        logic [`ETH_HDR_LEN*8-1:0] eth;
        logic [`ARP_HDR_LEN*8-1:0] body;
        int                        i;
        eth  = {48'hffff_ffff_ffff, sha, etype};
        body = {`ARP_HTYPE_ETH, ptype, hlen, `ARP_PLEN_IPV4, oper, sha, spa, 48'h0, tpa};
        for (i = `ETH_HDR_LEN - 1; i >= 0; i--) begin
            q.push_back(eth[i*8 +: 8]);
        end
        for (i = `ARP_HDR_LEN - 1; i >= 0; i--) begin
            q.push_back(body[i*8 +: 8]);
        end
        while (q.size() < len) begin
            q.push_back(8'h00);
        end
        while (q.size() > len) begin
            void'(q.pop_back());
        end
        return q;
    endfunction

    task automatic send_frame(input byte_q_t bytes, input logic user);
        int i;
        for (i = 0; i < bytes.size(); i++) begin
            // occasional idle cycle between beats
            if (($random(seed) & 3) == 0) begin
                @(negedge clk);
                s_tvalid = 1'b0;
            end
            @(negedge clk);
            s_tdata  = bytes[i];
            s_tvalid = 1'b1;
            s_tlast  = (i == bytes.size() - 1);
            s_tuser  = user && (i == bytes.size() - 1);
            // ready only changes on the rising edge
            while (!s_tready) begin
                @(negedge clk);
            end
            sent_bytes++;
        end
        @(negedge clk);
        s_tvalid = 1'b0;
        s_tlast  = 1'b0;
        s_tuser  = 1'b0;
    endtask

    task automatic clear_events();
        req_sha_q.delete();
        req_spa_q.delete();
        upd_ip_q.delete();
        upd_mac_q.delete();
        n_short = 0;
        n_early = 0;
        n_inv   = 0;
        n_busy  = 0;
    endtask

    task automatic wait_req(input int n);
        while (req_spa_q.size() < n) begin
            @(negedge clk);
        end
    endtask

    task automatic wait_upd(input int n);
        while (upd_ip_q.size() < n) begin
            @(negedge clk);
        end
    endtask

    task automatic wait_drop(input logic [15:0] target);
        while (drop_count < target) begin
            @(negedge clk);
        end
    endtask

    task automatic check_quiet(input logic [15:0] drops);
        check_val("drop_count", drops, drop_count);
        check_val("err_short_eth count", 0, n_short);
        check_val("err_early_term count", 0, n_early);
        check_val("err_invalid_hdr count", 0, n_inv);
    endtask

    task automatic request_to_us();
        clear_events();
        send_frame(build_arp(`ETHERTYPE_ARP, `ARP_PTYPE_IPV4, `ARP_HLEN_ETH, ARP_OP_REQUEST,
                             48'h02_11_22_33_44_55, 32'hc0a8_0101, LOCAL_IP, 60), 1'b0);
        wait_req(1);
        check_val("req count", 1, req_spa_q.size());
        check_val("req_sha", 48'h02_11_22_33_44_55, req_sha_q[0]);
        check_val("req_spa", 32'hc0a8_0101, req_spa_q[0]);
        check_val("upd count", 0, upd_ip_q.size());
        // busy spans at least one cycle per body byte, and drops once the body is read
        check_val("busy cycles reaching body length", 1, n_busy >= `ARP_HDR_LEN);
        check_val("busy after frame", 0, busy);
        check_quiet(16'd0);
    endtask

    task automatic reply_to_us();
        clear_events();
        send_frame(build_arp(`ETHERTYPE_ARP, `ARP_PTYPE_IPV4, `ARP_HLEN_ETH, ARP_OP_REPLY,
                             48'h02_aa_bb_cc_dd_ee, 32'hc0a8_0102, LOCAL_IP, ARP_FRAME_LEN),
                   1'b0);
        wait_upd(1);
        check_val("upd count", 1, upd_ip_q.size());
        check_val("upd_ip", 32'hc0a8_0102, upd_ip_q[0]);
        check_val("upd_mac", 48'h02_aa_bb_cc_dd_ee, upd_mac_q[0]);
        check_val("req count", 0, req_spa_q.size());
        check_quiet(16'd0);
    endtask

    task automatic filtered_frames();
        logic [15:0] d0;
        clear_events();
        d0 = drop_count;
        send_frame(build_arp(`ETHERTYPE_ARP, `ARP_PTYPE_IPV4, `ARP_HLEN_ETH, ARP_OP_REQUEST,
                             48'h02_00_00_00_00_01, 32'hc0a8_0103, 32'hc0a8_0199, 60), 1'b0);
        wait_drop(d0 + 16'd1);
        send_frame(build_arp(16'h0800, `ARP_PTYPE_IPV4, `ARP_HLEN_ETH, ARP_OP_REQUEST,
                             48'h02_00_00_00_00_02, 32'hc0a8_0104, LOCAL_IP, 60), 1'b0);
        wait_drop(d0 + 16'd2);
        send_frame(build_arp(`ETHERTYPE_ARP, 16'h86dd, `ARP_HLEN_ETH, ARP_OP_REQUEST,
                             48'h02_00_00_00_00_03, 32'hc0a8_0105, LOCAL_IP, 60), 1'b0);
        wait_drop(d0 + 16'd3);
        check_val("req count", 0, req_spa_q.size());
        check_val("upd count", 0, upd_ip_q.size());
        // a bad frame from the MAC, then a good reply marks when it has gone through
        send_frame(build_arp(`ETHERTYPE_ARP, `ARP_PTYPE_IPV4, `ARP_HLEN_ETH, ARP_OP_REQUEST,
                             48'h02_00_00_00_00_04, 32'hc0a8_0106, LOCAL_IP, 60), 1'b1);
        send_frame(build_arp(`ETHERTYPE_ARP, `ARP_PTYPE_IPV4, `ARP_HLEN_ETH, ARP_OP_REPLY,
                             48'h02_00_00_00_00_05, 32'hc0a8_0107, LOCAL_IP, 60), 1'b0);
        wait_upd(1);
        check_val("upd count", 1, upd_ip_q.size());
        check_val("upd_ip", 32'hc0a8_0107, upd_ip_q[0]);
        check_val("req count", 0, req_spa_q.size());
        check_quiet(d0 + 16'd3);
    endtask

    task automatic malformed_frames();
        logic [15:0] d0;
        d0 = drop_count;
        clear_events();
        send_frame(build_arp(`ETHERTYPE_ARP, `ARP_PTYPE_IPV4, `ARP_HLEN_ETH, ARP_OP_REQUEST,
                             48'h02_00_00_00_00_06, 32'hc0a8_0108, LOCAL_IP,
                             `ETH_HDR_LEN + 20), 1'b0);
        while (n_early == 0) begin
            @(negedge clk);
        end
        check_val("err_early_term count", 1, n_early);
        check_val("err_invalid_hdr count", 0, n_inv);
        check_val("err_short_eth count", 0, n_short);
        // counts run on so that a late event from an earlier frame is still seen
        send_frame(build_arp(`ETHERTYPE_ARP, `ARP_PTYPE_IPV4, 8'd5, ARP_OP_REQUEST,
                             48'h02_00_00_00_00_07, 32'hc0a8_0109, LOCAL_IP, ARP_FRAME_LEN),
                   1'b0);
        while (n_inv == 0) begin
            @(negedge clk);
        end
        check_val("err_invalid_hdr count", 1, n_inv);
        check_val("err_early_term count", 1, n_early);
        check_val("err_short_eth count", 0, n_short);
        send_frame(build_arp(`ETHERTYPE_ARP, `ARP_PTYPE_IPV4, `ARP_HLEN_ETH, ARP_OP_REQUEST,
                             48'h02_00_00_00_00_08, 32'hc0a8_010a, LOCAL_IP, 10), 1'b0);
        while (n_short == 0) begin
            @(negedge clk);
        end
        check_val("err_short_eth count", 1, n_short);
        check_val("err_early_term count", 1, n_early);
        check_val("err_invalid_hdr count", 1, n_inv);
        check_val("req count", 0, req_spa_q.size());
        check_val("upd count", 0, upd_ip_q.size());
        check_val("drop_count", d0, drop_count);
    endtask

    task automatic backpressure_order();
        byte_q_t     frames [3];
        logic [15:0] d0;
        int          base;
        int          stall_at;
        int          i;
        clear_events();
        d0 = drop_count;
        for (i = 0; i < 3; i++) begin
            frames[i] = build_arp(`ETHERTYPE_ARP, `ARP_PTYPE_IPV4, `ARP_HLEN_ETH,
                                  ARP_OP_REQUEST, 48'h02_00_00_00_01_00 + i,
                                  32'hc0a8_0111 + i, LOCAL_IP, ARP_FRAME_LEN);
        end
        @(negedge clk);
        req_ready = 1'b0;
        base = sent_bytes;
        stall_at = base + 2 * ARP_FRAME_LEN + `ETH_HDR_LEN;
        fork
            begin
                send_frame(frames[0], 1'b0);
                send_frame(frames[1], 1'b0);
                send_frame(frames[2], 1'b0);
            end
            begin
                // one request pending, one frame in the decoder, one header held
                while (!(req_valid && sent_bytes >= stall_at)) begin
                    @(negedge clk);
                end
                repeat (10) @(negedge clk);
                check_val("s_tready while stalled", 0, s_tready);
                check_val("req count while stalled", 0, req_spa_q.size());
                req_ready = 1'b1;
            end
        join
        wait_req(3);
        check_val("req count", 3, req_spa_q.size());
        for (i = 0; i < 3; i++) begin
            check_val("req_sha", 48'h02_00_00_00_01_00 + i, req_sha_q[i]);
            check_val("req_spa", 32'hc0a8_0111 + i, req_spa_q[i]);
        end
        check_val("upd count", 0, upd_ip_q.size());
        check_quiet(d0);
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        local_ip   = LOCAL_IP;
        s_tdata    = 8'h00;
        s_tvalid   = 1'b0;
        s_tlast    = 1'b0;
        s_tuser    = 1'b0;
        req_ready  = 1'b1;
        seed       = 74;
        errors     = 0;
        checks     = 0;
        cycles     = 0;
        sent_bytes = 0;
        clear_events();
        repeat (8) @(posedge clk);
        @(negedge clk);
        check_val("s_tready in reset", 0, s_tready);
        check_val("req_valid in reset", 0, req_valid);
        check_val("upd_valid in reset", 0, upd_valid);
        check_val("busy in reset", 0, busy);
        check_val("drop_count in reset", 0, drop_count);
        check_val("error pulses in reset", 0, {err_short_eth, err_early_term, err_invalid_hdr});
        rst = 1'b0;
        request_to_us();
        reply_to_us();
        filtered_frames();
        malformed_frames();
        backpressure_order();
        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- flist.f
+incdir+include
hdl/arp_pkg.sv
hdl/eth_hdr_rx.sv
hdl/arp_rx_decode.sv
hdl/arp_rx_filter.sv
hdl/arp_rx_top.sv
verif/arp_rx_tb.sv
